// ==== frameBuffer.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module frameBuffer (
  input logic clk,
  input logic wrEn,
  input logic [`MANDEL_ADDR_W-1:0] wrAddr,
  input mandelPkg::colorT wrColor,
  input logic [`MANDEL_ADDR_W-1:0] rdAddr,
  output mandelPkg::colorT rdColor
);
  import mandelPkg::*;

  localparam int depth = `MANDEL_FRAME_W * `MANDEL_FRAME_H;

  // one colour per pixel, row-major
  colorT mem [depth];

  always_ff @(posedge clk) begin
    if (wrEn && wrAddr < `MANDEL_ADDR_W'(depth)) begin
      mem[wrAddr] <= wrColor;
    end
  end

  // registered read, addresses past the frame read as black
  always_ff @(posedge clk) begin
    if (rdAddr < `MANDEL_ADDR_W'(depth)) begin
      rdColor <= mem[rdAddr];
    end else begin
      rdColor <= '0;
    end
  end

endmodule

// ==== loadDistributor.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module loadDistributor (
  input logic clk,
  input logic reset,
  input logic start,
  output logic frameDone,
  jobIf.distributor jobs [`MANDEL_NUM_PROC]
);
  import mandelPkg::*;

  localparam int numProc = `MANDEL_NUM_PROC;
  localparam int idxW = (numProc > 1) ? $clog2(numProc) : 1;
  localparam int frameW = `MANDEL_FRAME_W;
  localparam int frameH = `MANDEL_FRAME_H;
  localparam int colW = (frameW > 1) ? $clog2(frameW) : 1;
  localparam int rowW = (frameH > 1) ? $clog2(frameH) : 1;
  localparam int addrW = `MANDEL_ADDR_W;

  distStateT state;
  logic [numProc-1:0] readyVec;
  logic [numProc-1:0] dataValR;
  logic [numProc-1:0] avail;
  logic [idxW-1:0] rrPtr;
  int pick;

  logic [colW-1:0] col;
  logic [rowW-1:0] row;
  logic [addrW-1:0] pixIndex;
  fixT curX;
  fixT curY;
  fixT jobX;
  fixT jobY;
  logic [addrW-1:0] jobAddr;

  // job fields are shared, only the dataVal line selects the target
  for (genvar g = 0; g < numProc; g++) begin : genJobs
    assign readyVec[g] = jobs[g].procReady;
    assign jobs[g].dataVal = dataValR[g];
    assign jobs[g].coordX = jobX;
    assign jobs[g].coordY = jobY;
    assign jobs[g].pixAddr = jobAddr;
  end

  // a processor pulsed this cycle still shows ready until the next edge
  assign avail = readyVec & ~dataValR;
  assign pick = rrPick(avail, int'(rrPtr));
  assign pixIndex = addrW'(row) * addrW'(frameW) + addrW'(col);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= distIdle;
      dataValR <= '0;
      frameDone <= 1'b0;
      rrPtr <= '0;
      col <= '0;
      row <= '0;
    end else begin
      dataValR <= '0;
      frameDone <= 1'b0;
      case (state)
        distIdle: begin
          if (start) begin
            state <= distScan;
            col <= '0;
            row <= '0;
            curX <= `MANDEL_X_MIN;
            curY <= `MANDEL_Y_MIN;
          end
        end
        distScan: begin
          if (pick >= 0) begin
            dataValR[pick] <= 1'b1;
            rrPtr <= idxW'((pick + 1) % numProc);
            jobX <= curX;
            jobY <= curY;
            jobAddr <= pixIndex;
            // walk along the row, then step down
            if (col == colW'(frameW - 1)) begin
              col <= '0;
              curX <= `MANDEL_X_MIN;
              row <= row + 1'b1;
              curY <= curY + `MANDEL_STEP;
              if (row == rowW'(frameH - 1)) begin
                state <= distDrain;
              end
            end else begin
              col <= col + 1'b1;
              curX <= curX + `MANDEL_STEP;
            end
          end
        end
        distDrain: begin
          // last result is written before its processor turns ready
          if (dataValR == '0 && &readyVec) begin
            frameDone <= 1'b1;
            state <= distIdle;
          end
        end
        default: state <= distIdle;
      endcase
    end
  end

  aJobToReady: assert property (@(posedge clk) disable iff (reset)
    (dataValR & ~readyVec) == '0);

endmodule

// ==== mandelChecker.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandelChecker (
  input logic clk,
  input logic reset,
  input logic start,
  input logic frameDone,
  input logic pixelWrite,
  input logic [`MANDEL_ADDR_W-1:0] pixelAddr,
  input mandelPkg::colorT pixelColor,
  input logic [`MANDEL_ADDR_W-1:0] rdAddr,
  input mandelPkg::colorT rdColor,
  input logic readCheck,
  output int errorCount,
  output int readCount
);
  import mandelPkg::*;

  localparam int numPix = `MANDEL_FRAME_W * `MANDEL_FRAME_H;
  // 4.0 as a raw fixed-point value
  localparam fixT escapeBound = 36'sd1073741824;

  colorT expColor [numPix];
  int hits [numPix];
  int errs;
  int reads;
  int missing;
  int firstMissing;
  logic active;
  logic readPending;
  logic [`MANDEL_ADDR_W-1:0] readAddr;

  // escape-time colour of one pixel, taken from its linear address
  function automatic colorT refColor(input int addr);
    fixT cx;
    fixT cy;
    fixT zr;
    fixT zi;
    fixT zrSq;
    fixT ziSq;
    fixT zrZi;
    logic signed [2*`MANDEL_FIX_W-1:0] prod;
    int n;
    int lg;
    bit escaped;
    cx = `MANDEL_X_MIN + fixT'(addr % `MANDEL_FRAME_W) * `MANDEL_STEP;
    cy = `MANDEL_Y_MIN + fixT'(addr / `MANDEL_FRAME_W) * `MANDEL_STEP;
    zr = '0;
    zi = '0;
    n = 0;
    escaped = 1'b0;
    while (!escaped && n < `MANDEL_MAX_ITER) begin
      prod = zr * zr;
      zrSq = fixT'(prod >>> `MANDEL_FRAC_W);
      prod = zi * zi;
      ziSq = fixT'(prod >>> `MANDEL_FRAC_W);
      prod = zr * zi;
      zrZi = fixT'(prod >>> `MANDEL_FRAC_W);
      if (zrSq + ziSq > escapeBound) begin
        escaped = 1'b1;
      end else begin
        zr = zrSq - ziSq + cx;
        zi = 2 * zrZi + cy;
        n++;
      end
    end
    // floor(log2(n)), zero when n is zero
    lg = 0;
    for (int b = 1; b < 31; b++) begin
      if (n >= (1 << b)) lg = b;
    end
    return escaped ? colorT'(lg >> 1) : colorT'(0);
  endfunction

  initial begin
    for (int a = 0; a < numPix; a++) begin
      expColor[a] = refColor(a);
      hits[a] = 0;
    end
    errs = 0;
    reads = 0;
    active = 1'b0;
    readPending = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      active = 1'b0;
      readPending = 1'b0;
    end else begin
      // rdColor belongs to the address sampled one edge earlier
      if (readPending) begin
        reads++;
        if (rdColor !== expColor[readAddr]) begin
          errs++;
          $display("** Error: rdColor at rdAddr 0x%03h: expected 0x%0h, got 0x%0h",
                   readAddr, expColor[readAddr], rdColor);
        end
      end
      readPending = readCheck;
      readAddr = rdAddr;
      if (pixelWrite) begin
        if (!active || pixelAddr >= numPix) begin
          errs++;
          $display("write to address 0x%03h outside a running frame", pixelAddr);
        end else begin
          if (hits[pixelAddr] != 0) begin
            errs++;
            $display("address 0x%03h was written twice in one frame", pixelAddr);
          end
          hits[pixelAddr]++;
          if (pixelColor !== expColor[pixelAddr]) begin
            errs++;
            $display("** Error: pixelColor at pixelAddr 0x%03h: expected 0x%0h, got 0x%0h",
                     pixelAddr, expColor[pixelAddr], pixelColor);
          end
        end
      end
      if (frameDone) begin
        missing = 0;
        firstMissing = 0;
        for (int a = numPix - 1; a >= 0; a--) begin
          if (hits[a] == 0) begin
            missing++;
            firstMissing = a;
          end
        end
        if (!active) begin
          errs++;
          $display("frameDone pulsed while no frame was running");
        end else if (missing != 0) begin
          errs++;
          $display("frameDone came with %0d addresses never written, first one 0x%03h",
                   missing, firstMissing);
        end
        active = 1'b0;
      end else if (start && !active) begin
        // the distributor ignores start while a frame runs
        for (int a = 0; a < numPix; a++) begin
          hits[a] = 0;
        end
        active = 1'b1;
      end
    end
    errorCount <= errs;
    readCount <= reads;
  end

endmodule

// ==== mandelIfs.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

// one pixel job from the distributor to a processor
interface jobIf;
  import mandelPkg::*;

  logic dataVal;
  fixT coordX;
  fixT coordY;
  logic [`MANDEL_ADDR_W-1:0] pixAddr;
  // level, high while the processor is idle
  logic procReady;

  modport distributor (
    output dataVal,
    output coordX,
    output coordY,
    output pixAddr,
    input procReady
  );

  modport processor (
    input dataVal,
    input coordX,
    input coordY,
    input pixAddr,
    output procReady
  );
endinterface

// finished pixel from a processor to the arbiter
interface resultIf;
  import mandelPkg::*;

  colorT color;
  logic [`MANDEL_ADDR_W-1:0] pixAddr;
  // held until valueStored comes back
  logic resultVal;
  logic valueStored;

  modport processor (output color, output pixAddr, output resultVal, input valueStored);

  modport arbiter (input color, input pixAddr, input resultVal, output valueStored);
endinterface

// ==== mandelPkg.sv ====
`include "mandel_defines.svh"

package mandelPkg;

  typedef logic signed [`MANDEL_FIX_W-1:0] fixT;

  // escape code written to the frame buffer
  typedef logic [2:0] colorT;

  typedef enum logic [1:0] {procIdle, procIterate, procStore} procStateT;

  typedef enum logic [1:0] {distIdle, distScan, distDrain} distStateT;

  // rotating priority pick, returns -1 when no request is set
  // ptr is the index that wins first
  function automatic int rrPick(input logic [`MANDEL_NUM_PROC-1:0] req, input int ptr);
    int pick;
    pick = -1;
    for (int k = `MANDEL_NUM_PROC - 1; k >= 0; k--) begin
      if (req[(ptr + k) % `MANDEL_NUM_PROC]) begin
        pick = (ptr + k) % `MANDEL_NUM_PROC;
      end
    end
    return pick;
  endfunction

endpackage

// ==== mandelTb.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandelTb;
  import mandelPkg::*;

  localparam int numPix = `MANDEL_FRAME_W * `MANDEL_FRAME_H;
  localparam int frameTimeout = 200000;
  localparam int readTimeout = 20;

  logic clk;
  logic reset;
  logic start;
  logic [`MANDEL_ADDR_W-1:0] rdAddr;
  logic readCheck;
  logic frameDone;
  logic pixelWrite;
  logic [`MANDEL_ADDR_W-1:0] pixelAddr;
  colorT pixelColor;
  colorT rdColor;
  int errorCount;
  int readCount;
  int testsPassed;
  int testsFailed;
  int errorsBefore;
  bit timedOut;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  mandelTop i_mandelTop (
    .clk(clk),
    .reset(reset),
    .start(start),
    .frameDone(frameDone),
    .pixelWrite(pixelWrite),
    .pixelAddr(pixelAddr),
    .pixelColor(pixelColor),
    .rdAddr(rdAddr),
    .rdColor(rdColor)
  );

  mandelChecker i_mandelChecker (
    .clk(clk),
    .reset(reset),
    .start(start),
    .frameDone(frameDone),
    .pixelWrite(pixelWrite),
    .pixelAddr(pixelAddr),
    .pixelColor(pixelColor),
    .rdAddr(rdAddr),
    .rdColor(rdColor),
    .readCheck(readCheck),
    .errorCount(errorCount),
    .readCount(readCount)
  );

  task automatic printCounts();
    $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic pulseStart();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic waitFrameDone();
    int cycles;
    bit seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < frameTimeout) begin
      @(posedge clk);
      cycles++;
      if (frameDone) seen = 1'b1;
    end
    if (!seen) begin
      $display("timeout: frameDone never arrived");
      timedOut = 1'b1;
    end
  endtask

  // sweep every address while the checker compares one cycle later
  task automatic readBack();
    int target;
    int cycles;
    target = readCount + numPix;
    for (int a = 0; a < numPix; a++) begin
      @(posedge clk);
      rdAddr <= `MANDEL_ADDR_W'(a);
      readCheck <= 1'b1;
    end
    @(posedge clk);
    readCheck <= 1'b0;
    cycles = 0;
    while (readCount < target && cycles < readTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (readCount < target) begin
      $display("timeout: frame buffer readback did not complete");
      timedOut = 1'b1;
    end
  endtask

  // wait for frameDone and settle before the buffer is read back
  task automatic finishFrame(input int settle);
    waitFrameDone();
    if (!timedOut) begin
      idleCycles(settle);
      readBack();
    end
  endtask

  task automatic endTest(input int num, input string name);
    idleCycles(4);
    if (errorCount == errorsBefore && !timedOut) begin
      testsPassed++;
      $display("test %0d %s: pass", num, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: fail with %0d errors", num, name, errorCount - errorsBefore);
    end
    errorsBefore = errorCount;
  endtask

  task automatic runTests();
    pulseStart();
    finishFrame(0);
    endTest(1, "first frame");
    if (timedOut) return;

    idleCycles($urandom_range(5, 60));
    pulseStart();
    finishFrame(0);
    endTest(2, "restart after gap");
    if (timedOut) return;

    // extra start pulses inside a running frame
    pulseStart();
    idleCycles($urandom_range(20, 200));
    pulseStart();
    idleCycles($urandom_range(20, 200));
    pulseStart();
    finishFrame(200);
    endTest(3, "start during frame");
    if (timedOut) return;

    pulseStart();
    idleCycles($urandom_range(100, 600));
    reset <= 1'b1;
    idleCycles($urandom_range(1, 6));
    reset <= 1'b0;
    idleCycles(30);
    pulseStart();
    finishFrame(0);
    endTest(4, "reset mid-frame");
  endtask

  initial begin
    void'($urandom(32'h2142));
    reset = 1'b1;
    start = 1'b0;
    rdAddr = '0;
    readCheck = 1'b0;
    testsPassed = 0;
    testsFailed = 0;
    errorsBefore = 0;
    timedOut = 1'b0;
    idleCycles(4);
    reset <= 1'b0;

    runTests();

    printCounts();
    if (!timedOut && testsFailed == 0 && errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== mandelTop.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandelTop (
  input logic clk,
  input logic reset,
  input logic start,
  output logic frameDone,
  output logic pixelWrite,
  output logic [`MANDEL_ADDR_W-1:0] pixelAddr,
  output mandelPkg::colorT pixelColor,
  input logic [`MANDEL_ADDR_W-1:0] rdAddr,
  output mandelPkg::colorT rdColor
);

  jobIf jobBus [`MANDEL_NUM_PROC] ();
  resultIf resultBus [`MANDEL_NUM_PROC] ();

  loadDistributor i_loadDistributor (
    .clk(clk),
    .reset(reset),
    .start(start),
    .frameDone(frameDone),
    .jobs(jobBus)
  );

  // escape-time engines working side by side
  for (genvar g = 0; g < `MANDEL_NUM_PROC; g++) begin : genProc
    mandelbrotProcessor #(
      .maxIterations(`MANDEL_MAX_ITER)
    ) i_mandelbrotProcessor (
      .clk(clk),
      .reset(reset),
      .job(jobBus[g]),
      .result(resultBus[g])
    );
  end

  // write strobe goes both to the buffer and out of the top
  resultArbiter i_resultArbiter (
    .clk(clk),
    .reset(reset),
    .results(resultBus),
    .wrEn(pixelWrite),
    .wrAddr(pixelAddr),
    .wrColor(pixelColor)
  );

  frameBuffer i_frameBuffer (
    .clk(clk),
    .wrEn(pixelWrite),
    .wrAddr(pixelAddr),
    .wrColor(pixelColor),
    .rdAddr(rdAddr),
    .rdColor(rdColor)
  );

endmodule

// ==== mandel_defines.svh ====
`ifndef MANDEL_DEFINES_SVH
`define MANDEL_DEFINES_SVH

// frame geometry, kept small so a full frame simulates quickly
`define MANDEL_FRAME_W 32
`define MANDEL_FRAME_H 24
`define MANDEL_ADDR_W 10

// signed fixed point, 8 integer bits including sign
`define MANDEL_FIX_W 36
`define MANDEL_FRAC_W 28

// pixel (0,0) sits at -2.0 - 1.125i, one pixel is 3/32
`define MANDEL_X_MIN (-36'sd536870912)
`define MANDEL_Y_MIN (-36'sd301989888)
`define MANDEL_STEP 36'sd25165824

`define MANDEL_NUM_PROC 4
`define MANDEL_MAX_ITER 64

`endif

// ==== mandelbrotProcessor.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandelbrotProcessor #(
  parameter int maxIterations = `MANDEL_MAX_ITER
) (
  input logic clk,
  input logic reset,
  jobIf.processor job,
  resultIf.processor result
);
  import mandelPkg::*;

  localparam int iterW = $clog2(maxIterations + 1);
  localparam int logW = (iterW > 1) ? $clog2(iterW) : 1;
  localparam int prodW = 2 * `MANDEL_FIX_W;
  // |z|^2 above this means the point has escaped
  localparam fixT escapeLimit = fixT'(4) <<< `MANDEL_FRAC_W;

  procStateT state;
  procStateT nextState;

  fixT cx;
  fixT cy;
  fixT zr;
  fixT zi;
  logic [iterW-1:0] count;
  logic [`MANDEL_ADDR_W-1:0] pixAddrR;
  colorT colorR;

  logic signed [prodW-1:0] fullRR;
  logic signed [prodW-1:0] fullII;
  logic signed [prodW-1:0] fullRI;
  fixT zrSq;
  fixT ziSq;
  fixT zrZi;
  fixT magSq;
  logic atLimit;
  logic escaped;
  logic [logW-1:0] log2Count;

  // full products, then drop the fraction bits
  assign fullRR = zr * zr;
  assign fullII = zi * zi;
  assign fullRI = zr * zi;
  assign zrSq = fixT'(fullRR >>> `MANDEL_FRAC_W);
  assign ziSq = fixT'(fullII >>> `MANDEL_FRAC_W);
  assign zrZi = fixT'(fullRI >>> `MANDEL_FRAC_W);

  assign magSq = zrSq + ziSq;
  assign escaped = magSq > escapeLimit;
  assign atLimit = count == iterW'(maxIterations);

  // floor(log2(count)) with zero for a zero count
  always_comb begin
    log2Count = '0;
    for (int b = 1; b < iterW; b++) begin
      if (count[b]) begin
        log2Count = logW'(b);
      end
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      procIdle: begin
        if (job.dataVal) begin
          nextState = procIterate;
        end
      end
      procIterate: begin
        if (atLimit || escaped) begin
          nextState = procStore;
        end
      end
      procStore: begin
        if (result.valueStored) begin
          nextState = procIdle;
        end
      end
      default: nextState = procIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= procIdle;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      procIdle: begin
        if (job.dataVal) begin
          cx <= job.coordX;
          cy <= job.coordY;
          pixAddrR <= job.pixAddr;
          zr <= '0;
          zi <= '0;
          count <= '0;
        end
      end
      procIterate: begin
        // limit wins over escape
        if (atLimit) begin
          colorR <= '0;
        end else if (escaped) begin
          colorR <= colorT'(log2Count >> 1);
        end else begin
          zr <= zrSq - ziSq + cx;
          zi <= (zrZi <<< 1) + cy;
          count <= count + 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign job.procReady = state == procIdle;
  assign result.resultVal = state == procStore;
  assign result.color = colorR;
  assign result.pixAddr = pixAddrR;

  aHoldResult: assert property (@(posedge clk) disable iff (reset)
    result.resultVal && !result.valueStored |=> result.resultVal);

  aDropAfterStore: assert property (@(posedge clk) disable iff (reset)
    result.valueStored |=> !result.resultVal && job.procReady);

endmodule

// ==== resultArbiter.sv ====
`timescale 1ns/1ps
`include "mandel_defines.svh"

module resultArbiter (
  input logic clk,
  input logic reset,
  resultIf.arbiter results [`MANDEL_NUM_PROC],
  output logic wrEn,
  output logic [`MANDEL_ADDR_W-1:0] wrAddr,
  output mandelPkg::colorT wrColor
);
  import mandelPkg::*;

  localparam int numProc = `MANDEL_NUM_PROC;
  localparam int idxW = (numProc > 1) ? $clog2(numProc) : 1;

  logic [numProc-1:0] resultVec;
  logic [numProc-1:0] pending;
  logic [numProc-1:0] storedR;
  colorT colorVec [numProc];
  logic [`MANDEL_ADDR_W-1:0] addrVec [numProc];
  logic [idxW-1:0] rrPtr;
  int pick;

  for (genvar g = 0; g < numProc; g++) begin : genResults
    assign resultVec[g] = results[g].resultVal;
    assign colorVec[g] = results[g].color;
    assign addrVec[g] = results[g].pixAddr;
    assign results[g].valueStored = storedR[g];
  end

  // the processor stored this cycle still holds resultVal until the edge
  assign pending = resultVec & ~storedR;
  assign pick = rrPick(pending, int'(rrPtr));

  always_ff @(posedge clk) begin
    if (reset) begin
      storedR <= '0;
      wrEn <= 1'b0;
      rrPtr <= '0;
    end else begin
      storedR <= '0;
      wrEn <= 1'b0;
      if (pick >= 0) begin
        storedR[pick] <= 1'b1;
        wrEn <= 1'b1;
        rrPtr <= idxW'((pick + 1) % numProc);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pick >= 0) begin
      wrAddr <= addrVec[pick];
      wrColor <= colorVec[pick];
    end
  end

  aOneStored: assert property (@(posedge clk) disable iff (reset) $onehot0(storedR));

  aStoredWasPending: assert property (@(posedge clk) disable iff (reset)
    (storedR & ~resultVec) == '0);

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the Mandelbrot testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module mandelTb -o mandelSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/mandelSim 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// ==== sources.f ====
+incdir+.
mandelPkg.sv
mandelIfs.sv
loadDistributor.sv
mandelbrotProcessor.sv
resultArbiter.sv
frameBuffer.sv
mandelTop.sv
mandelChecker.sv
mandelTb.sv
